// ==== include/soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Byte-address width of the data memory, which gives 256 words
`define RAM_WIDTH 10

// Address windows on the memory bus, in word addresses
`define DATA_BASE 30'h000
`define DATA_SIZE 30'd256

`define UART_BASE 30'h100
`define UART_SIZE 30'd4

`endif

// ==== hw/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

   // Command that a master puts on the shared memory bus next to its
   // address and write strobe
   typedef struct packed {
      logic        mem_read;
      logic [3:0]  mask_byte;   // One bit per byte lane
      logic [31:0] write_data;
   } bus_cmd_t;

   // Read data returned by the selected slave
   typedef logic [31:0] bus_result_t;

endpackage

`default_nettype wire

// ==== hw/cpu_mem_pkg.sv ====
`default_nettype none

package cpu_mem_pkg;

   // Memory operation requested by the core for the current instruction
   typedef enum logic [3:0] {
      MEM_NONE,
      LB,
      LH,
      LW,
      LBU,
      LHU,
      SB,
      SH,
      SW
   } mem_inst_type_t;

   // Byte lanes of a 32-bit word, lane 0 is the least significant byte
   typedef logic [3:0] byte_mask_t;

endpackage

`default_nettype wire

// ==== hw/master_bus_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module master_bus_mux #(
   parameter type TCmd    = mem_bus_pkg::bus_cmd_t,
   parameter type TResult = mem_bus_pkg::bus_result_t
) (
   input  logic        use_a_i,

   input  logic [29:0] address_a_i,
   input  logic        write_enable_a_i,
   input  TCmd         cmd_a_i,
   output TResult      result_a_o,

   input  logic [29:0] address_b_i,
   input  logic        write_enable_b_i,
   input  TCmd         cmd_b_i,
   output TResult      result_b_o,

   output logic [29:0] address_o,
   output logic        write_enable_o,
   output TCmd         cmd_o,
   input  TResult      result_i
);

   always_comb begin
      if (use_a_i) begin
         address_o      = address_a_i;
         write_enable_o = write_enable_a_i;
         cmd_o          = cmd_a_i;
      end else begin
         address_o      = address_b_i;
         write_enable_o = write_enable_b_i;
         cmd_o          = cmd_b_i;
      end

      // A strobe from the idle master must never reach the slaves
      a_we_from_owner: assert (!write_enable_o ||
                               (use_a_i ? write_enable_a_i : write_enable_b_i))
         else $error("Common write strobe not driven by the bus owner");
   end

   assign result_a_o = result_i; // Both masters see the same read data
   assign result_b_o = result_i;

endmodule

`default_nettype wire

// ==== hw/slave_bus_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module slave_bus_mux #(
   parameter type TCmd    = mem_bus_pkg::bus_cmd_t,
   parameter type TResult = mem_bus_pkg::bus_result_t
) (
   input  logic        clk,
   input  logic        reset_i,

   input  logic [29:0] address_i,
   input  logic        we_i,
   input  TCmd         cmd_i,
   output TResult      result_o,

   output logic [29:0] address_1_o,
   output logic        we_1_o,
   output TCmd         cmd_1_o,
   input  TResult      result_1_i,

   output logic [29:0] address_2_o,
   output logic        we_2_o,
   output TCmd         cmd_2_o,
   input  TResult      result_2_i,

   output logic        bus_fault_o
);

   logic [29:0] offset_1;
   logic [29:0] offset_2;
   logic        hit_1;
   logic        hit_2;
   logic        fault_q;

   // Unsigned wrap makes addresses below a base fall outside its window
   assign offset_1 = address_i - `DATA_BASE;
   assign offset_2 = address_i - `UART_BASE;
   assign hit_1    = offset_1 < `DATA_SIZE;
   assign hit_2    = offset_2 < `UART_SIZE;

   assign address_1_o = hit_1 ? offset_1 : '0;
   assign we_1_o      = we_i & hit_1;
   assign cmd_1_o     = hit_1 ? cmd_i : '0;

   assign address_2_o = hit_2 ? offset_2 : '0;
   assign we_2_o      = we_i & hit_2;
   assign cmd_2_o     = hit_2 ? cmd_i : '0;

   always_comb begin
      if (hit_1) begin
         result_o = result_1_i;
      end else if (hit_2) begin
         result_o = result_2_i;
      end else begin
         result_o = '0; // Unmapped reads return zero
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         fault_q <= 1'b0;
      end else if (we_i && !hit_1 && !hit_2) begin
         fault_q <= 1'b1; // Held until the next reset
      end
   end

   assign bus_fault_o = fault_q;

   a_one_slave_we: assert property (@(posedge clk) disable iff (reset_i)
      !(we_1_o && we_2_o))
      else $error("Write strobe routed to both slaves");

endmodule

`default_nettype wire

// ==== hw/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module data_mem (
   input  logic                    clk,
   input  logic                    write_enable_i,
   input  logic [`RAM_WIDTH-3:0]   address_i,
   input  mem_bus_pkg::bus_cmd_t   cmd_i,
   output mem_bus_pkg::bus_result_t result_o
);

   localparam int unsigned DEPTH = 2 ** (`RAM_WIDTH - 2);

   logic [31:0] mem_q [0:DEPTH-1];

   always_ff @(posedge clk) begin
      if (write_enable_i) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (cmd_i.mask_byte[lane]) begin
               mem_q[address_i][8*lane +: 8] <= cmd_i.write_data[8*lane +: 8];
            end
         end
      end
   end

   assign result_o = mem_q[address_i]; // Reads do not wait for a clock edge

   // The controller and the probe always name at least one lane on a write
   a_write_has_mask: assert property (@(posedge clk)
      write_enable_i |-> (cmd_i.mask_byte != 4'b0000))
      else $error("Memory write with an empty byte mask");

endmodule

`default_nettype wire

// ==== hw/controller_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module controller_mem (
   input  logic [1:0]                  byte_offset_i,
   input  cpu_mem_pkg::mem_inst_type_t inst_type_i,
   input  logic [31:0]                 write_data_i,
   output logic [31:0]                 read_data_o,
   output logic                        exception_o,

   input  mem_bus_pkg::bus_result_t    bus_result_i,
   output mem_bus_pkg::bus_cmd_t       cmd_o,
   output logic                        write_o
);

   import cpu_mem_pkg::*;

   byte_mask_t  lane_mask;
   logic        is_load;
   logic        is_store;
   logic        misaligned;
   logic [31:0] shifted;

   // Lane selection and alignment check
   always_comb begin
      lane_mask  = '0;
      misaligned = 1'b0;
      case (inst_type_i)
         LB, LBU, SB: begin
            lane_mask = byte_mask_t'(4'b0001 << byte_offset_i);
         end
         LH, LHU, SH: begin
            lane_mask  = byte_offset_i[1] ? 4'b1100 : 4'b0011;
            misaligned = byte_offset_i[0];
         end
         LW, SW: begin
            lane_mask  = 4'b1111;
            misaligned = |byte_offset_i;
         end
         default: begin
            lane_mask = '0;
         end
      endcase
   end

   assign is_load  = inst_type_i inside {LB, LH, LW, LBU, LHU};
   assign is_store = inst_type_i inside {SB, SH, SW};

   assign shifted = bus_result_i >> {byte_offset_i, 3'b000}; // Selected lanes moved to bit 0

   always_comb begin
      case (inst_type_i)
         SB:      cmd_o.write_data = {4{write_data_i[7:0]}};
         SH:      cmd_o.write_data = {2{write_data_i[15:0]}};
         default: cmd_o.write_data = write_data_i;
      endcase

      case (inst_type_i)
         LB:      read_data_o = {{24{shifted[7]}}, shifted[7:0]};
         LBU:     read_data_o = {24'h000000, shifted[7:0]};
         LH:      read_data_o = {{16{shifted[15]}}, shifted[15:0]};
         LHU:     read_data_o = {16'h0000, shifted[15:0]};
         LW:      read_data_o = bus_result_i;
         default: read_data_o = '0;
      endcase

      // Misaligned accesses never reach the bus
      cmd_o.mask_byte = misaligned ? 4'b0000 : lane_mask;
      cmd_o.mem_read  = is_load & ~misaligned;
      write_o         = is_store & ~misaligned;
      exception_o     = misaligned;

      a_no_read_write: assert (!(write_o && cmd_o.mem_read))
         else $error("Load and store strobes raised together");
   end

endmodule

`default_nettype wire

// ==== hw/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module mem_subsystem_top (
   input  logic                        clk,
   input  logic                        reset_i,

   input  logic                        probe_mem_i,
   input  logic [29:0]                 probe_address_i,
   input  logic                        probe_read_i,
   input  logic                        probe_write_i,
   input  cpu_mem_pkg::byte_mask_t     probe_mask_byte_i,
   input  logic [31:0]                 probe_write_data_i,
   output mem_bus_pkg::bus_result_t    probe_read_data_o,

   input  logic [31:0]                 cpu_address_i,
   input  cpu_mem_pkg::mem_inst_type_t cpu_inst_type_i,
   input  logic [31:0]                 cpu_write_data_i,
   output logic [31:0]                 cpu_read_data_o,
   output logic                        cpu_exception_o,

   output logic [7:0]                  uart_data_o,
   output logic                        uart_write_o,

   output logic                        bus_fault_o
);

   import mem_bus_pkg::*;

   bus_cmd_t    probe_cmd;
   bus_cmd_t    cpu_cmd;
   bus_result_t cpu_result;
   logic        cpu_write;

   logic [29:0] common_address;
   logic        common_write;
   bus_cmd_t    common_cmd;
   bus_result_t common_result;

   logic [29:0] data_address;
   logic        data_write;
   bus_cmd_t    data_cmd;
   bus_result_t data_result;

   bus_cmd_t    uart_cmd;

   assign probe_cmd.mem_read   = probe_read_i;
   assign probe_cmd.mask_byte  = probe_mask_byte_i;
   assign probe_cmd.write_data = probe_write_data_i;

   assign uart_data_o = uart_cmd.write_data[7:0];

   controller_mem i_controller_mem (
      .byte_offset_i (cpu_address_i[1:0]),
      .inst_type_i   (cpu_inst_type_i),
      .write_data_i  (cpu_write_data_i),
      .read_data_o   (cpu_read_data_o),
      .exception_o   (cpu_exception_o),
      .bus_result_i  (cpu_result),
      .cmd_o         (cpu_cmd),
      .write_o       (cpu_write)
   );

   master_bus_mux #(.TCmd(bus_cmd_t), .TResult(bus_result_t)) i_master_bus_mux (
      .use_a_i          (probe_mem_i),
      .address_a_i      (probe_address_i),
      .write_enable_a_i (probe_write_i),
      .cmd_a_i          (probe_cmd),
      .result_a_o       (probe_read_data_o),
      .address_b_i      (cpu_address_i[31:2]),
      .write_enable_b_i (cpu_write),
      .cmd_b_i          (cpu_cmd),
      .result_b_o       (cpu_result),
      .address_o        (common_address),
      .write_enable_o   (common_write),
      .cmd_o            (common_cmd),
      .result_i         (common_result)
   );

   slave_bus_mux #(.TCmd(bus_cmd_t), .TResult(bus_result_t)) i_slave_bus_mux (
      .clk         (clk),
      .reset_i     (reset_i),
      .address_i   (common_address),
      .we_i        (common_write),
      .cmd_i       (common_cmd),
      .result_o    (common_result),
      .address_1_o (data_address),
      .we_1_o      (data_write),
      .cmd_1_o     (data_cmd),
      .result_1_i  (data_result),
      .address_2_o (),
      .we_2_o      (uart_write_o),
      .cmd_2_o     (uart_cmd),
      .result_2_i  ('0), // The UART port has nothing to read back
      .bus_fault_o (bus_fault_o)
   );

   data_mem i_data_mem (
      .clk            (clk),
      .write_enable_i (data_write),
      .address_i      (data_address[`RAM_WIDTH-3:0]),
      .cmd_i          (data_cmd),
      .result_o       (data_result)
   );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS = 100
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
   end

   always #(PERIOD_NS / 2) clk_o = ~clk_o; // First rising edge after half a period

endmodule

`default_nettype wire

// ==== dv/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module tb_mem_subsystem;

   import cpu_mem_pkg::*;

   localparam int RESET_CYCLES  = 10;
   localparam int BUDGET_CYCLES = RESET_CYCLES + 2 * 256 + 40 + 100 + 60 + 30 + 20 + 2 * 200;
   localparam int MARGIN_CYCLES = 200;
   localparam logic [29:0] CORE_WORD = 30'h020;
   localparam logic [29:0] MIS_WORD  = 30'h030;

   logic           clk;
   logic           reset;
   logic           probe_mem;
   logic [29:0]    probe_address;
   logic           probe_read;
   logic           probe_write;
   byte_mask_t     probe_mask;
   logic [31:0]    probe_wdata;
   logic [31:0]    probe_rdata;
   logic [31:0]    cpu_address;
   mem_inst_type_t cpu_inst_type;
   logic [31:0]    cpu_wdata;
   logic [31:0]    cpu_rdata;
   logic           cpu_exception;
   logic [7:0]     uart_data;
   logic           uart_write;
   logic           bus_fault;

   logic [31:0] ref_mem [0:255]; // Expected contents of the data memory
   int          error_count;
   int          check_count;
   int          test_count;
   int          seed;
   logic [31:0] core_rdata;
   logic        core_exc;
   logic        core_uart_we;
   logic [7:0]  core_uart_data;

   tb_clock_gen #(.PERIOD_NS(100)) i_tb_clock_gen (.clk_o(clk));

   mem_subsystem_top i_mem_subsystem_top (
      .clk                (clk),
      .reset_i            (reset),
      .probe_mem_i        (probe_mem),
      .probe_address_i    (probe_address),
      .probe_read_i       (probe_read),
      .probe_write_i      (probe_write),
      .probe_mask_byte_i  (probe_mask),
      .probe_write_data_i (probe_wdata),
      .probe_read_data_o  (probe_rdata),
      .cpu_address_i      (cpu_address),
      .cpu_inst_type_i    (cpu_inst_type),
      .cpu_write_data_i   (cpu_wdata),
      .cpu_read_data_o    (cpu_rdata),
      .cpu_exception_o    (cpu_exception),
      .uart_data_o        (uart_data),
      .uart_write_o       (uart_write),
      .bus_fault_o        (bus_fault)
   );

   task automatic compare_value(input string what, input logic [31:0] actual,
                                input logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      test_count++;
      $display("Test %s: %s", name, (error_count == errors_before) ? "passed" : "failed");
   endtask

   function automatic logic [31:0] fill_word(input logic [7:0] w);
      return {8'hC3 ^ w, w, ~w, 8'h5A + w};
   endfunction

   function automatic void model_write(input logic [29:0] addr, input logic [3:0] mask,
                                       input logic [31:0] data);
      if (addr < `DATA_SIZE) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (mask[lane]) ref_mem[addr[7:0]][8*lane +: 8] = data[8*lane +: 8];
         end
      end
   endfunction

   // Store data starts at the addressed byte, low byte of the register first
   function automatic void model_store(input mem_inst_type_t op, input logic [31:0] byte_addr,
                                       input logic [31:0] data);
      int size;
      int base;
      size = (op == SB) ? 1 : (op == SH) ? 2 : 4;
      base = int'(byte_addr[1:0]);
      for (int k = 0; k < size; k++) begin
         ref_mem[byte_addr[9:2]][8*(base+k) +: 8] = data[8*k +: 8];
      end
   endfunction

   function automatic logic [31:0] load_value(input mem_inst_type_t op, input logic [31:0] word,
                                              input int off);
      int          size;
      logic        sign;
      logic [31:0] raw;
      raw  = '0;
      size = (op == LW) ? 4 : (op == LH || op == LHU) ? 2 : 1;
      for (int k = 0; k < size; k++) raw[8*k +: 8] = word[8*(off+k) +: 8];
      sign = (op == LB || op == LH) ? raw[8*size-1] : 1'b0;
      for (int k = size; k < 4; k++) raw[8*k +: 8] = {8{sign}};
      return raw;
   endfunction

   task automatic probe_write_word(input logic [29:0] addr, input logic [3:0] mask,
                                   input logic [31:0] data);
      @(posedge clk);
      probe_mem     <= 1'b1;
      probe_address <= addr;
      probe_read    <= 1'b0;
      probe_write   <= 1'b1;
      probe_mask    <= mask;
      probe_wdata   <= data;
      @(posedge clk);
      probe_write <= 1'b0; // Memory took the word on this edge
      model_write(addr, mask, data);
   endtask

   task automatic probe_read_word(input logic [29:0] addr, output logic [31:0] data);
      @(posedge clk);
      probe_mem     <= 1'b1;
      probe_address <= addr;
      probe_read    <= 1'b1;
      probe_write   <= 1'b0;
      @(negedge clk);
      data = probe_rdata;
   endtask

   task automatic core_access(input mem_inst_type_t op, input logic [31:0] addr,
                              input logic [31:0] data);
      @(posedge clk);
      probe_mem     <= 1'b0;
      probe_read    <= 1'b0;
      probe_write   <= 1'b0;
      cpu_address   <= addr;
      cpu_inst_type <= op;
      cpu_wdata     <= data;
      @(negedge clk);
      core_rdata     = cpu_rdata;
      core_exc       = cpu_exception;
      core_uart_we   = uart_write;
      core_uart_data = uart_data;
      @(posedge clk);
      cpu_inst_type <= MEM_NONE;
   endtask

   task automatic preload_memory();
      for (int w = 0; w < 256; w++) probe_write_word(30'(w), 4'hF, fill_word(8'(w)));
   endtask

   task automatic probe_word_access();
      int          errors_before;
      logic [31:0] rd;
      errors_before = error_count;
      for (int i = 0; i < 12; i++) begin
         probe_write_word(30'h010 + 30'(i), 4'((i * 7) % 15 + 1),
                          32'h1357_9BDF ^ (32'(i) * 32'h0101_0101));
      end
      for (int i = 0; i < 12; i++) begin
         probe_read_word(30'h010 + 30'(i), rd);
         compare_value($sformatf("probe read of word %0d", 16 + i), rd, ref_mem[16 + i]);
      end
      report_test("probe_word_access", errors_before);
   endtask

   task automatic run_store(input mem_inst_type_t op, input int off);
      logic [31:0] addr;
      logic [31:0] rd;
      addr = {CORE_WORD, off[1:0]};
      probe_write_word(CORE_WORD, 4'hF, 32'hF08C_7E13);
      core_access(op, addr, 32'h9E37_79B9 + 32'(off));
      model_store(op, addr, 32'h9E37_79B9 + 32'(off));
      compare_value($sformatf("%s exception at offset %0d", op.name(), off), 32'(core_exc), 0);
      probe_read_word(CORE_WORD, rd);
      compare_value($sformatf("%s result at offset %0d", op.name(), off), rd,
                    ref_mem[CORE_WORD[7:0]]);
   endtask

   task automatic run_load(input mem_inst_type_t op, input int off);
      core_access(op, {CORE_WORD, off[1:0]}, 32'h0);
      compare_value($sformatf("%s exception at offset %0d", op.name(), off), 32'(core_exc), 0);
      compare_value($sformatf("%s data at offset %0d", op.name(), off), core_rdata,
                    load_value(op, ref_mem[CORE_WORD[7:0]], off));
   endtask

   task automatic core_load_store();
      int errors_before;
      errors_before = error_count;
      for (int off = 0; off < 4; off++) run_store(SB, off);
      for (int off = 0; off < 4; off += 2) run_store(SH, off);
      run_store(SW, 0);
      probe_write_word(CORE_WORD, 4'hF, 32'hF08C_7E13); // Mixed signs across the lanes
      for (int off = 0; off < 4; off++) begin
         run_load(LB, off);
         run_load(LBU, off);
      end
      for (int off = 0; off < 4; off += 2) begin
         run_load(LH, off);
         run_load(LHU, off);
      end
      run_load(LW, 0);
      report_test("core_load_store", errors_before);
   endtask

   task automatic expect_exception(input mem_inst_type_t op, input int off);
      core_access(op, {MIS_WORD, off[1:0]}, 32'hDEAD_BEEF);
      compare_value($sformatf("%s exception at offset %0d", op.name(), off), 32'(core_exc), 1);
   endtask

   task automatic misaligned_access();
      int          errors_before;
      logic [31:0] rd;
      errors_before = error_count;
      probe_write_word(MIS_WORD, 4'hF, 32'h7766_5544);
      for (int off = 1; off < 4; off++) begin
         if (off != 2) begin
            expect_exception(LH, off);
            expect_exception(SH, off);
         end
         expect_exception(LW, off);
         expect_exception(SW, off);
      end
      probe_read_word(MIS_WORD, rd);
      compare_value("word after misaligned accesses", rd, ref_mem[MIS_WORD[7:0]]);
      report_test("misaligned_access", errors_before);
   endtask

   task automatic uart_window();
      int          errors_before;
      logic [31:0] rd;
      logic [7:0]  value;
      errors_before = error_count;
      for (int w = 0; w < 4; w++) begin
         value = 8'h41 + 8'(w);
         if (w[0]) begin
            core_access(SB, {`UART_BASE + 30'(w), w[1:0]}, {24'hFFFF00, value});
         end else begin
            core_access(SW, {`UART_BASE + 30'(w), 2'b00}, {24'h123400, value});
         end
         compare_value($sformatf("UART strobe for word %0d", w), 32'(core_uart_we), 1);
         compare_value($sformatf("UART byte for word %0d", w), 32'(core_uart_data), 32'(value));
         @(negedge clk);
         compare_value("UART strobe while idle", 32'(uart_write), 0);
      end
      for (int w = 0; w < 4; w++) begin
         probe_read_word(30'(w), rd);
         compare_value($sformatf("data word %0d after UART stores", w), rd, ref_mem[w]);
      end
      probe_read_word(`UART_BASE, rd);
      compare_value("UART read data", rd, 0);
      compare_value("bus fault after UART stores", 32'(bus_fault), 0);
      report_test("uart_window", errors_before);
   endtask

   task automatic unmapped_fault();
      int          errors_before;
      logic [31:0] rd;
      errors_before = error_count;
      @(negedge clk);
      compare_value("bus fault before unmapped write", 32'(bus_fault), 0);
      probe_write_word(30'h200, 4'hF, 32'h0BAD_0BAD);
      @(negedge clk);
      compare_value("bus fault after unmapped write", 32'(bus_fault), 1);
      repeat (3) @(posedge clk);
      @(negedge clk);
      compare_value("bus fault held", 32'(bus_fault), 1);
      @(posedge clk);
      reset <= 1'b1;
      @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      compare_value("bus fault after reset pulse", 32'(bus_fault), 0);
      probe_read_word(30'h200, rd);
      compare_value("unmapped read at word 200", rd, 0);
      probe_read_word(30'h3FFF_FFFF, rd);
      compare_value("unmapped read at top word", rd, 0);
      compare_value("bus fault after unmapped reads", 32'(bus_fault), 0);
      report_test("unmapped_fault", errors_before);
   endtask

   task automatic random_traffic();
      int          errors_before;
      logic [31:0] ctrl;
      logic [31:0] data;
      logic [31:0] rd;
      logic [3:0]  mask;
      errors_before = error_count;
      for (int i = 0; i < 200; i++) begin
         ctrl = $random(seed);
         data = $random(seed);
         mask = (ctrl[11:8] == 4'h0) ? 4'hF : ctrl[11:8]; // Memory rejects empty masks
         if (ctrl[16]) begin
            probe_write_word({22'h0, ctrl[7:0]}, mask, data);
         end else begin
            probe_read_word({22'h0, ctrl[7:0]}, rd);
            compare_value($sformatf("random read %0d of word %0d", i, ctrl[7:0]), rd,
                          ref_mem[ctrl[7:0]]);
         end
      end
      report_test("random_traffic", errors_before);
   endtask

   initial begin
      error_count = 0;
      check_count = 0;
      test_count  = 0;
      seed        = 32'h0626_1da5;
      reset         <= 1'b1;
      probe_mem     <= 1'b1;
      probe_address <= '0;
      probe_read    <= 1'b0;
      probe_write   <= 1'b0;
      probe_mask    <= 4'h0;
      probe_wdata   <= '0;
      cpu_address   <= '0;
      cpu_inst_type <= MEM_NONE;
      cpu_wdata     <= '0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      preload_memory();
      probe_word_access();
      core_load_store();
      misaligned_access();
      uart_window();
      unmapped_fault();
      random_traffic();
      $display("Summary: %0d tests, %0d checks, %0d failed checks",
               test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin
      repeat (BUDGET_CYCLES + MARGIN_CYCLES) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d clock cycles",
               BUDGET_CYCLES + MARGIN_CYCLES);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
hw/mem_bus_pkg.sv
hw/cpu_mem_pkg.sv
hw/master_bus_mux.sv
hw/slave_bus_mux.sv
hw/data_mem.sv
hw/controller_mem.sv
hw/mem_subsystem_top.sv
dv/tb_clock_gen.sv
dv/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_mem_subsystem

rm -rf "$BUILD_DIR"
rm -f "$LOG_FILE"

verilator --binary --timing --assert -j 0 \
   --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP" \
   -f vlog.f
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

# The run passes only if the testbench printed its pass line
if grep -qx "No errors" "$LOG_FILE"; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed, see $LOG_FILE"
exit 1
